/* source/rv_backend_settings.svh */
`ifndef RV_BACKEND_SETTINGS_SVH
`define RV_BACKEND_SETTINGS_SVH

// width of data words and byte addresses
`define DATA_LEN 32

// width of an integer register index
`define REG_ADDR_LEN 5

// number of integer registers, x0 included
`define REG_COUNT 32

`endif

/* source/csr_defs_pkg.sv */
package csr_defs_pkg;

    // csr index width from the privileged spec
    localparam int CSR_ADDR_LEN = 12;

    typedef logic [CSR_ADDR_LEN-1:0] csr_addr_t;

    // csr access kinds, matching csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_t;

    // machine mode registers at their standard addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

endpackage

/* source/pipe_types_pkg.sv */
`include "rv_backend_settings.svh"

package pipe_types_pkg;

    import csr_defs_pkg::*;

    typedef logic [`DATA_LEN-1:0] data_t;
    typedef logic [`REG_ADDR_LEN-1:0] reg_addr_t;

    // memory access kind carried from execute
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_kind_t;

    // execute to memory stage payload
    typedef struct packed {
        logic      reg_we;
        reg_addr_t rd;
        // also the memory address for loads and stores
        data_t     alu_result;
        data_t     store_data;
        mem_kind_t mem_kind;
        csr_op_t   csr_op;
        csr_addr_t csr_addr;
        data_t     csr_wdata;
        logic      ebreak;
    } ex_to_ms_t;

    // memory to writeback stage payload
    typedef struct packed {
        logic      reg_we;
        reg_addr_t rd;
        data_t     reg_wdata;
        csr_op_t   csr_op;
        csr_addr_t csr_addr;
        data_t     csr_wdata;
        logic      ebreak;
    } ms_to_ws_t;

    // retire report, qualified by retire_valid
    typedef struct packed {
        reg_addr_t rd;
        data_t     wdata;
        logic      ebreak;
    } retire_t;

endpackage

/* source/pipe_latch.sv */
module pipe_latch #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     allowin_o,
    input  logic     ready_go_i,
    input  logic     out_allowin_i,
    output logic     out_valid_o,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the held item leaves this cycle
    assign allowin_o = !valid_q || (ready_go_i && out_allowin_i);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (allowin_o) begin
            valid_q <= in_valid_i;
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clock) begin
        if (in_valid_i && allowin_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

/* source/mem_stage.sv */
`include "rv_backend_settings.svh"

module mem_stage import pipe_types_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    valid_i,
    input  ex_to_ms_t               item_i,
    output logic                    ready_go_o,
    output ms_to_ws_t               item_o,
    output logic                    dmem_req_o,
    output logic                    dmem_we_o,
    output logic [`DATA_LEN-1:0]    dmem_addr_o,
    output logic [`DATA_LEN-1:0]    dmem_wdata_o,
    output logic [`DATA_LEN/8-1:0]  dmem_wstrb_o,
    input  logic                    dmem_rvalid_i,
    input  logic [`DATA_LEN-1:0]    dmem_rdata_i
);

    logic       req_pending;
    logic       is_mem;
    logic       is_store;
    logic       is_load;
    logic [1:0] byte_off;
    data_t      lane_data;
    data_t      load_val;

    assign is_mem   = item_i.mem_kind != MEM_NONE;
    assign is_store = item_i.mem_kind inside {MEM_SB, MEM_SH, MEM_SW};
    assign is_load  = is_mem && !is_store;
    assign byte_off = item_i.alu_result[1:0];

    // one request per item, then wait for the response pulse
    assign dmem_req_o  = valid_i && is_mem && !req_pending;
    assign dmem_we_o   = is_store;
    assign dmem_addr_o = item_i.alu_result;

    always_ff @(posedge clock) begin
        if (reset) begin
            req_pending <= 1'b0;
        end else if (dmem_rvalid_i) begin
            req_pending <= 1'b0;
        end else if (dmem_req_o) begin
            req_pending <= 1'b1;
        end
    end

    // ready_go already includes valid, so it doubles as the outgoing valid
    assign ready_go_o = valid_i && (!is_mem || (req_pending && dmem_rvalid_i));

    // store lanes: shift by the byte offset
    assign dmem_wdata_o = item_i.store_data << {byte_off, 3'b000};

    always_comb begin
        case (item_i.mem_kind)
            MEM_SB:  dmem_wstrb_o = 4'b0001 << byte_off;
            MEM_SH:  dmem_wstrb_o = byte_off[1] ? 4'b1100 : 4'b0011;
            MEM_SW:  dmem_wstrb_o = 4'b1111;
            default: dmem_wstrb_o = 4'b0000;
        endcase
    end

    // bring the addressed byte or half down to bit 0
    assign lane_data = dmem_rdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (item_i.mem_kind)
            MEM_LB:  load_val = {{(`DATA_LEN-8){lane_data[7]}}, lane_data[7:0]};
            MEM_LH:  load_val = {{(`DATA_LEN-16){lane_data[15]}}, lane_data[15:0]};
            MEM_LBU: load_val = {{(`DATA_LEN-8){1'b0}}, lane_data[7:0]};
            MEM_LHU: load_val = {{(`DATA_LEN-16){1'b0}}, lane_data[15:0]};
            default: load_val = dmem_rdata_i;
        endcase
    end

    always_comb begin
        item_o.reg_we    = item_i.reg_we;
        item_o.rd        = item_i.rd;
        // loaded value overrides the alu result
        item_o.reg_wdata = is_load ? load_val : item_i.alu_result;
        item_o.csr_op    = item_i.csr_op;
        item_o.csr_addr  = item_i.csr_addr;
        item_o.csr_wdata = item_i.csr_wdata;
        item_o.ebreak    = item_i.ebreak;
    end

endmodule

/* source/wb_stage.sv */
`include "rv_backend_settings.svh"

module wb_stage import pipe_types_pkg::*, csr_defs_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     valid_i,
    input  ms_to_ws_t                item_i,
    output logic                     allowin_o,
    output logic                     rf_we_o,
    output logic [`REG_ADDR_LEN-1:0] rf_waddr_o,
    output logic [`DATA_LEN-1:0]     rf_wdata_o,
    output csr_op_t                  csr_op_o,
    output csr_addr_t                csr_addr_o,
    output logic [`DATA_LEN-1:0]     csr_wdata_o,
    output logic                     retire_valid_o,
    output retire_t                  retire_o
);

    // last stage never stalls
    assign allowin_o = 1'b1;

    // control side, masked by valid
    always_ff @(posedge clock) begin
        if (reset) begin
            rf_we_o        <= 1'b0;
            csr_op_o       <= CSR_NONE;
            retire_valid_o <= 1'b0;
        end else begin
            rf_we_o        <= item_i.reg_we & valid_i;
            csr_op_o       <= valid_i ? item_i.csr_op : CSR_NONE;
            retire_valid_o <= valid_i;
        end
    end

    // payload side
    always_ff @(posedge clock) begin
        retire_o.rd     <= item_i.rd;
        retire_o.wdata  <= item_i.reg_wdata;
        retire_o.ebreak <= item_i.ebreak;
        csr_addr_o      <= item_i.csr_addr;
        csr_wdata_o     <= item_i.csr_wdata;
    end

    // register file write shares the retire payload
    assign rf_waddr_o = retire_o.rd;
    assign rf_wdata_o = retire_o.wdata;

endmodule

/* source/reg_file.sv */
`include "rv_backend_settings.svh"

module reg_file (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     we_i,
    input  logic [`REG_ADDR_LEN-1:0] waddr_i,
    input  logic [`DATA_LEN-1:0]     wdata_i,
    input  logic [`REG_ADDR_LEN-1:0] raddr_a_i,
    output logic [`DATA_LEN-1:0]     rdata_a_o,
    input  logic [`REG_ADDR_LEN-1:0] raddr_b_i,
    output logic [`DATA_LEN-1:0]     rdata_b_o
);

    logic [`DATA_LEN-1:0] regs [`REG_COUNT];

    // synchronous write, x0 never stored
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // asynchronous reads, x0 forced to zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

/* source/csr_file.sv */
`include "rv_backend_settings.svh"

module csr_file import csr_defs_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  csr_op_t              op_i,
    input  csr_addr_t            addr_i,
    input  logic [`DATA_LEN-1:0] wdata_i,
    input  csr_addr_t            raddr_i,
    output logic [`DATA_LEN-1:0] rdata_o
);

    logic [`DATA_LEN-1:0] mstatus_q;
    logic [`DATA_LEN-1:0] mtvec_q;
    logic [`DATA_LEN-1:0] mepc_q;
    logic [`DATA_LEN-1:0] mcause_q;
    logic [`DATA_LEN-1:0] cur_val;
    logic [`DATA_LEN-1:0] next_val;

    // unmapped addresses read as zero
    function automatic logic [`DATA_LEN-1:0] csr_select(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS: return mstatus_q;
            CSR_MTVEC:   return mtvec_q;
            CSR_MEPC:    return mepc_q;
            CSR_MCAUSE:  return mcause_q;
            default:     return '0;
        endcase
    endfunction

    // write / set / clear on the old value
    function automatic logic [`DATA_LEN-1:0] csr_apply(
        input logic [`DATA_LEN-1:0] old_val,
        input csr_op_t              op,
        input logic [`DATA_LEN-1:0] arg
    );
        case (op)
            CSR_WRITE: return arg;
            CSR_SET:   return old_val | arg;
            CSR_CLEAR: return old_val & ~arg;
            default:   return old_val;
        endcase
    endfunction

    // old value of the target and its update
    always_comb begin
        cur_val  = csr_select(addr_i);
        next_val = csr_apply(cur_val, op_i, wdata_i);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (op_i != CSR_NONE) begin
            case (addr_i)
                CSR_MSTATUS: mstatus_q <= next_val;
                CSR_MTVEC:   mtvec_q   <= next_val;
                // mepc is word aligned
                CSR_MEPC:    mepc_q    <= {next_val[`DATA_LEN-1:2], 2'b00};
                CSR_MCAUSE:  mcause_q  <= next_val;
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata_o = csr_select(raddr_i);
    end

endmodule

/* source/rv_backend.sv */
`include "rv_backend_settings.svh"

module rv_backend import pipe_types_pkg::*, csr_defs_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     ex_valid_i,
    input  ex_to_ms_t                ex_item_i,
    output logic                     ms_allowin_o,
    output logic                     dmem_req_o,
    output logic                     dmem_we_o,
    output logic [`DATA_LEN-1:0]     dmem_addr_o,
    output logic [`DATA_LEN-1:0]     dmem_wdata_o,
    output logic [`DATA_LEN/8-1:0]   dmem_wstrb_o,
    input  logic                     dmem_rvalid_i,
    input  logic [`DATA_LEN-1:0]     dmem_rdata_i,
    input  logic [`REG_ADDR_LEN-1:0] rf_raddr_a_i,
    output logic [`DATA_LEN-1:0]     rf_rdata_a_o,
    input  logic [`REG_ADDR_LEN-1:0] rf_raddr_b_i,
    output logic [`DATA_LEN-1:0]     rf_rdata_b_o,
    input  csr_addr_t                csr_raddr_i,
    output logic [`DATA_LEN-1:0]     csr_rdata_o,
    output logic                     retire_valid_o,
    output retire_t                  retire_o
);

    // memory stage side
    logic      ms_valid;
    ex_to_ms_t ms_item;
    logic      ms_ready_go;
    ms_to_ws_t ms_item_out;
    logic      ws_latch_allowin;

    // writeback side
    logic      ws_valid;
    ms_to_ws_t ws_item;
    logic      wb_allowin;

    // commit buses
    logic                     rf_we;
    logic [`REG_ADDR_LEN-1:0] rf_waddr;
    logic [`DATA_LEN-1:0]     rf_wdata;
    csr_op_t                  csr_op;
    csr_addr_t                csr_addr;
    logic [`DATA_LEN-1:0]     csr_wdata;

    // execute to memory latch
    pipe_latch #(.payload_t(ex_to_ms_t)) u_ms_latch (
        .clock         (clock),
        .reset         (reset),
        .in_valid_i    (ex_valid_i),
        .in_data_i     (ex_item_i),
        .allowin_o     (ms_allowin_o),
        .ready_go_i    (ms_ready_go),
        .out_allowin_i (ws_latch_allowin),
        .out_valid_o   (ms_valid),
        .out_data_o    (ms_item)
    );

    mem_stage u_mem_stage (
        .clock         (clock),
        .reset         (reset),
        .valid_i       (ms_valid),
        .item_i        (ms_item),
        .ready_go_o    (ms_ready_go),
        .item_o        (ms_item_out),
        .dmem_req_o    (dmem_req_o),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .dmem_wstrb_o  (dmem_wstrb_o),
        .dmem_rvalid_i (dmem_rvalid_i),
        .dmem_rdata_i  (dmem_rdata_i)
    );

    // memory to writeback latch
    // ready_go carries valid, so it feeds in_valid directly
    pipe_latch #(.payload_t(ms_to_ws_t)) u_ws_latch (
        .clock         (clock),
        .reset         (reset),
        .in_valid_i    (ms_ready_go),
        .in_data_i     (ms_item_out),
        .allowin_o     (ws_latch_allowin),
        .ready_go_i    (1'b1),
        .out_allowin_i (wb_allowin),
        .out_valid_o   (ws_valid),
        .out_data_o    (ws_item)
    );

    wb_stage u_wb_stage (
        .clock          (clock),
        .reset          (reset),
        .valid_i        (ws_valid),
        .item_i         (ws_item),
        .allowin_o      (wb_allowin),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .csr_op_o       (csr_op),
        .csr_addr_o     (csr_addr),
        .csr_wdata_o    (csr_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    reg_file u_reg_file (
        .clock     (clock),
        .reset     (reset),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rf_raddr_a_i),
        .rdata_a_o (rf_rdata_a_o),
        .raddr_b_i (rf_raddr_b_i),
        .rdata_b_o (rf_rdata_b_o)
    );

    csr_file u_csr_file (
        .clock   (clock),
        .reset   (reset),
        .op_i    (csr_op),
        .addr_i  (csr_addr),
        .wdata_i (csr_wdata),
        .raddr_i (csr_raddr_i),
        .rdata_o (csr_rdata_o)
    );

endmodule

/* test/rv_backend_checker.sv */
`include "rv_backend_settings.svh"

module rv_backend_checker import pipe_types_pkg::*, csr_defs_pkg::*; #(
    parameter int NUM_TESTS = 1
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     retire_valid_i,
    input  retire_t                  retire_i,
    input  logic [`DATA_LEN-1:0]     rf_rdata_a_i,
    input  logic [`DATA_LEN-1:0]     rf_rdata_b_i,
    input  logic [`DATA_LEN-1:0]     csr_rdata_i,
    input  ex_to_ms_t                items_i [NUM_TESTS],
    input  logic [`DATA_LEN-1:0]     exp_wdata_i [NUM_TESTS],
    input  logic [`DATA_LEN-1:0]     exp_csr_i [NUM_TESTS],
    output logic [`REG_ADDR_LEN-1:0] probe_rd_o,
    output logic [`REG_ADDR_LEN-1:0] probe_rd_b_o,
    output csr_addr_t                probe_csr_o,
    output logic                     done_o,
    output int                       pass_count_o,
    output int                       fail_count_o,
    output int                       stray_count_o
);

    int                       next_idx;
    int                       probe_idx;
    logic                     probe_pending;
    logic                     entry_bad;
    logic [`DATA_LEN-1:0]     exp_reg;
    logic [`REG_ADDR_LEN-1:0] last_rd;
    logic [`DATA_LEN-1:0]     shadow_regs [`REG_COUNT];

    initial begin
        next_idx      = 0;
        probe_idx     = 0;
        probe_pending = 1'b0;
        entry_bad     = 1'b0;
        last_rd       = '0;
        probe_rd_o    = '0;
        probe_rd_b_o  = '0;
        probe_csr_o   = '0;
        done_o        = 1'b0;
        pass_count_o  = 0;
        fail_count_o  = 0;
        stray_count_o = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow_regs[i] = '0;
        end
    end

    // compare one value and mark the current test bad
    task automatic compare_value(input string name, input int idx,
                                 input logic [`DATA_LEN-1:0] expected,
                                 input logic [`DATA_LEN-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s in test %0d: expected %h, got %h", name, idx, expected, actual);
            entry_bad = 1'b1;
        end
    endtask

    // sample at the falling edge where outputs are settled
    always @(negedge clock) begin
        if (!reset) begin
            // readback of the entry that retired one cycle ago
            if (probe_pending) begin
                if (items_i[probe_idx].reg_we) begin
                    // x0 keeps reading zero
                    exp_reg = (items_i[probe_idx].rd == '0) ? '0 : exp_wdata_i[probe_idx];
                    compare_value("rf_rdata_a_o", probe_idx, exp_reg, rf_rdata_a_i);
                end
                // port b looks at a register written by an earlier entry
                compare_value("rf_rdata_b_o", probe_idx, shadow_regs[probe_rd_b_o],
                              rf_rdata_b_i);
                if (items_i[probe_idx].csr_op != CSR_NONE) begin
                    compare_value("csr_rdata_o", probe_idx, exp_csr_i[probe_idx], csr_rdata_i);
                end
                if (entry_bad) begin
                    fail_count_o++;
                    $display("test %0d failed", probe_idx);
                end else begin
                    pass_count_o++;
                    $display("test %0d ok", probe_idx);
                end
                probe_pending = 1'b0;
            end
            // retire order must follow the table
            if (retire_valid_i) begin
                if (next_idx >= NUM_TESTS) begin
                    stray_count_o++;
                    $display("An extra retire for rd %0d came after the last test", retire_i.rd);
                end else begin
                    entry_bad = 1'b0;
                    compare_value("retire_o.rd", next_idx, items_i[next_idx].rd, retire_i.rd);
                    compare_value("retire_o.wdata", next_idx, exp_wdata_i[next_idx],
                                  retire_i.wdata);
                    compare_value("retire_o.ebreak", next_idx, items_i[next_idx].ebreak,
                                  retire_i.ebreak);
                    probe_idx     = next_idx;
                    probe_pending = 1'b1;
                    probe_rd_o    = items_i[next_idx].rd;
                    probe_rd_b_o  = last_rd;
                    probe_csr_o   = items_i[next_idx].csr_addr;
                    // expected register contents after this entry commits
                    if (items_i[next_idx].reg_we && (items_i[next_idx].rd != '0)) begin
                        shadow_regs[items_i[next_idx].rd] = exp_wdata_i[next_idx];
                        last_rd = items_i[next_idx].rd;
                    end
                    next_idx++;
                end
            end
            done_o = (next_idx == NUM_TESTS) && !probe_pending;
        end
    end

endmodule

/* test/rv_backend_tb.sv */
`include "rv_backend_settings.svh"

module rv_backend_tb import pipe_types_pkg::*, csr_defs_pkg::*;;

    localparam int NUM_TESTS      = 28;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 8 + RESET_CYCLES + 20;

    logic                     clock;
    logic                     reset;
    logic                     ex_valid;
    ex_to_ms_t                ex_item;
    logic                     ms_allowin;
    logic                     dmem_req;
    logic                     dmem_we;
    logic [`DATA_LEN-1:0]     dmem_addr;
    logic [`DATA_LEN-1:0]     dmem_wdata;
    logic [`DATA_LEN/8-1:0]   dmem_wstrb;
    logic                     dmem_rvalid;
    logic [`DATA_LEN-1:0]     dmem_rdata;
    logic [`REG_ADDR_LEN-1:0] rf_raddr_a;
    logic [`REG_ADDR_LEN-1:0] rf_raddr_b;
    logic [`DATA_LEN-1:0]     rf_rdata_a;
    logic [`DATA_LEN-1:0]     rf_rdata_b;
    csr_addr_t                csr_raddr;
    logic [`DATA_LEN-1:0]     csr_rdata;
    logic                     retire_valid;
    retire_t                  retire;

    // stimulus table and expected results
    ex_to_ms_t            items [NUM_TESTS];
    logic [`DATA_LEN-1:0] exp_wdata [NUM_TESTS];
    logic [`DATA_LEN-1:0] exp_csr [NUM_TESTS];
    int                   n_added = 0;

    logic [`DATA_LEN-1:0]     dmem [64];
    logic [`REG_ADDR_LEN-1:0] probe_rd;
    logic [`REG_ADDR_LEN-1:0] probe_rd_b;
    csr_addr_t                probe_csr;
    logic                     chk_done;
    int                       pass_count;
    int                       fail_count;
    int                       stray_count;
    int                       cycle_count = 0;

    rv_backend u_dut (
        .clock          (clock),
        .reset          (reset),
        .ex_valid_i     (ex_valid),
        .ex_item_i      (ex_item),
        .ms_allowin_o   (ms_allowin),
        .dmem_req_o     (dmem_req),
        .dmem_we_o      (dmem_we),
        .dmem_addr_o    (dmem_addr),
        .dmem_wdata_o   (dmem_wdata),
        .dmem_wstrb_o   (dmem_wstrb),
        .dmem_rvalid_i  (dmem_rvalid),
        .dmem_rdata_i   (dmem_rdata),
        .rf_raddr_a_i   (rf_raddr_a),
        .rf_rdata_a_o   (rf_rdata_a),
        .rf_raddr_b_i   (rf_raddr_b),
        .rf_rdata_b_o   (rf_rdata_b),
        .csr_raddr_i    (csr_raddr),
        .csr_rdata_o    (csr_rdata),
        .retire_valid_o (retire_valid),
        .retire_o       (retire)
    );

    rv_backend_checker #(.NUM_TESTS(NUM_TESTS)) u_checker (
        .clock          (clock),
        .reset          (reset),
        .retire_valid_i (retire_valid),
        .retire_i       (retire),
        .rf_rdata_a_i   (rf_rdata_a),
        .rf_rdata_b_i   (rf_rdata_b),
        .csr_rdata_i    (csr_rdata),
        .items_i        (items),
        .exp_wdata_i    (exp_wdata),
        .exp_csr_i      (exp_csr),
        .probe_rd_o     (probe_rd),
        .probe_rd_b_o   (probe_rd_b),
        .probe_csr_o    (probe_csr),
        .done_o         (chk_done),
        .pass_count_o   (pass_count),
        .fail_count_o   (fail_count),
        .stray_count_o  (stray_count)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic ex_to_ms_t alu_item(input reg_addr_t rd, input data_t value,
                                           input logic brk);
        ex_to_ms_t it;
        it            = '0;
        it.reg_we     = 1'b1;
        it.rd         = rd;
        it.alu_result = value;
        it.ebreak     = brk;
        return it;
    endfunction

    // rd of zero marks a store without a register write
    function automatic ex_to_ms_t mem_item(input mem_kind_t kind, input reg_addr_t rd,
                                           input data_t addr, input data_t sdata);
        ex_to_ms_t it;
        it            = '0;
        it.reg_we     = (rd != '0);
        it.rd         = rd;
        it.alu_result = addr;
        it.store_data = sdata;
        it.mem_kind   = kind;
        return it;
    endfunction

    function automatic ex_to_ms_t csr_item(input csr_op_t op, input csr_addr_t addr,
                                           input data_t value);
        ex_to_ms_t it;
        it           = '0;
        it.csr_op    = op;
        it.csr_addr  = addr;
        it.csr_wdata = value;
        return it;
    endfunction

    task automatic add_test(input ex_to_ms_t item, input data_t wdata, input data_t csr_val);
        items[n_added]     = item;
        exp_wdata[n_added] = wdata;
        exp_csr[n_added]   = csr_val;
        n_added++;
    endtask

    task automatic build_table();
        // plain alu results, x0 write, one ebreak
        add_test(alu_item(5'd1, 32'h1234_5678, 1'b0), 32'h1234_5678, '0);
        add_test(alu_item(5'd2, 32'hdead_beef, 1'b0), 32'hdead_beef, '0);
        add_test(alu_item(5'd0, 32'hffff_ffff, 1'b0), 32'hffff_ffff, '0);
        add_test(alu_item(5'd3, 32'h0000_0042, 1'b1), 32'h0000_0042, '0);
        // word at 0x40 is 8081_7f01 with bytes 01 7f 81 80 from lane 0 up
        add_test(mem_item(MEM_LB, 5'd4, 32'h40, '0), 32'h0000_0001, '0);
        add_test(mem_item(MEM_LB, 5'd5, 32'h41, '0), 32'h0000_007f, '0);
        add_test(mem_item(MEM_LB, 5'd6, 32'h42, '0), 32'hffff_ff81, '0);
        add_test(mem_item(MEM_LB, 5'd7, 32'h43, '0), 32'hffff_ff80, '0);
        add_test(mem_item(MEM_LBU, 5'd17, 32'h40, '0), 32'h0000_0001, '0);
        add_test(mem_item(MEM_LBU, 5'd8, 32'h41, '0), 32'h0000_007f, '0);
        add_test(mem_item(MEM_LBU, 5'd9, 32'h42, '0), 32'h0000_0081, '0);
        add_test(mem_item(MEM_LBU, 5'd10, 32'h43, '0), 32'h0000_0080, '0);
        add_test(mem_item(MEM_LH, 5'd11, 32'h40, '0), 32'h0000_7f01, '0);
        add_test(mem_item(MEM_LH, 5'd12, 32'h42, '0), 32'hffff_8081, '0);
        add_test(mem_item(MEM_LHU, 5'd13, 32'h40, '0), 32'h0000_7f01, '0);
        add_test(mem_item(MEM_LHU, 5'd14, 32'h42, '0), 32'h0000_8081, '0);
        add_test(mem_item(MEM_LW, 5'd15, 32'h40, '0), 32'h8081_7f01, '0);
        // word at 0x44 starts as 1122_3344
        // stores retire their address
        add_test(mem_item(MEM_SB, 5'd0, 32'h45, 32'h0000_00aa), 32'h0000_0045, '0);
        add_test(mem_item(MEM_SH, 5'd0, 32'h46, 32'h0000_beef), 32'h0000_0046, '0);
        add_test(mem_item(MEM_SB, 5'd0, 32'h44, 32'h0000_0055), 32'h0000_0044, '0);
        // 1122_3344 -> 1122_aa44 -> beef_aa44 -> beef_aa55
        add_test(mem_item(MEM_LW, 5'd16, 32'h44, '0), 32'hbeef_aa55, '0);
        // mstatus 1888 then set 0003 gives 188b then clear 0808 gives 1083
        add_test(csr_item(CSR_WRITE, CSR_MSTATUS, 32'h0000_1888), '0, 32'h0000_1888);
        add_test(csr_item(CSR_SET, CSR_MSTATUS, 32'h0000_0003), '0, 32'h0000_188b);
        add_test(csr_item(CSR_CLEAR, CSR_MSTATUS, 32'h0000_0808), '0, 32'h0000_1083);
        // mepc low two bits always read zero
        add_test(csr_item(CSR_WRITE, CSR_MEPC, 32'h8000_1237), '0, 32'h8000_1234);
        add_test(csr_item(CSR_SET, CSR_MEPC, 32'h0000_0f03), '0, 32'h8000_1f34);
        add_test(csr_item(CSR_CLEAR, CSR_MEPC, 32'h8000_0010), '0, 32'h0000_1f24);
        // unmapped csr
        add_test(csr_item(CSR_WRITE, 12'h7c0, 32'hffff_ffff), '0, '0);
    endtask

    // data memory serving one request at a time
    // 0 to 3 idle cycles before rvalid
    initial begin
        logic [`DATA_LEN-1:0] word;
        logic                 busy;
        int                   wait_left;
        int                   idx;
        int                   delay;
        void'($urandom(32'heb3c_e753));
        busy        = 1'b0;
        wait_left   = 0;
        word        = '0;
        dmem_rvalid = 1'b0;
        dmem_rdata  = '0;
        forever begin
            @(posedge clock);
            dmem_rvalid <= 1'b0;
            if (reset) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_left == 0) begin
                    dmem_rvalid <= 1'b1;
                    dmem_rdata  <= word;
                    busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end else if (dmem_req) begin
                idx  = dmem_addr[7:2];
                word = dmem[idx];
                if (dmem_we) begin
                    for (int b = 0; b < `DATA_LEN / 8; b++) begin
                        if (dmem_wstrb[b]) begin
                            dmem[idx][b*8 +: 8] = dmem_wdata[b*8 +: 8];
                        end
                    end
                end
                delay = $urandom_range(3, 0);
                if (delay == 0) begin
                    dmem_rvalid <= 1'b1;
                    dmem_rdata  <= word;
                end else begin
                    busy      = 1'b1;
                    wait_left = delay - 1;
                end
            end
        end
    end

    // aim the read ports at the registers under readback
    always @(posedge clock) begin
        rf_raddr_a <= probe_rd;
        rf_raddr_b <= probe_rd_b;
        csr_raddr  <= probe_csr;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timed out after %0d cycles: test %0d never retired",
                     cycle_count, pass_count + fail_count);
            $display("tests passed %0d, failed %0d, extra retires %0d",
                     pass_count, fail_count, stray_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        ex_valid   = 1'b0;
        ex_item    = '0;
        rf_raddr_a = '0;
        rf_raddr_b = '0;
        csr_raddr  = '0;
        // background differs per word before the test words go in
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hc0de_0000 | i;
        end
        dmem[16] = 32'h8081_7f01;
        dmem[17] = 32'h1122_3344;
        build_table();
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int k = 0; k < NUM_TESTS; k++) begin
            ex_valid <= 1'b1;
            ex_item  <= items[k];
            @(posedge clock);
            // held while the memory stage stalls
            while (!ms_allowin) begin
                @(posedge clock);
            end
        end
        ex_valid <= 1'b0;
        wait (chk_done);
        // room for any stray retire
        repeat (4) @(posedge clock);
        $display("tests passed %0d, failed %0d, extra retires %0d",
                 pass_count, fail_count, stray_count);
        if (pass_count == NUM_TESTS && fail_count == 0 && stray_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* rv_backend.f */
+incdir+source
source/csr_defs_pkg.sv
source/pipe_types_pkg.sv
source/pipe_latch.sv
source/mem_stage.sv
source/wb_stage.sv
source/reg_file.sv
source/csr_file.sv
source/rv_backend.sv
test/rv_backend_checker.sv
test/rv_backend_tb.sv
